//--- Bender.yml
package:
  name: kcpu

sources:
  - src/kcpuPkg.sv
  - src/kcpuAlu.sv
  - src/kcpuRegs.sv
  - src/kcpuAddr.sv
  - src/kcpuCtrl.sv
  - src/kcpuCore.sv
  - target: test
    files:
      - testbench/kcpuTb.sv

//--- kcpuCore.f
src/kcpuPkg.sv
src/kcpuAlu.sv
src/kcpuRegs.sv
src/kcpuAddr.sv
src/kcpuCtrl.sv
src/kcpuCore.sv
testbench/kcpuTb.sv

//--- src/kcpuAddr.sv
`timescale 1ns/1ps
`default_nettype none

module kcpuAddr #(
    parameter logic [15:0] resetAddr = 16'h0000
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        pcInc,
    input  logic        eaHiLd,
    input  logic        eaLoLd,
    input  logic        useEa,
    input  logic        writeHi,
    input  logic [7:0]  din,
    output logic [16-1:0] addr
);

    logic [15:0] pc;
    logic [15:0] ea;

    // Program counter, one step per opcode or operand byte
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetAddr;
        end else if (pcInc) begin
            pc <= pc + 16'd1;
        end
    end

    // Extended address, big endian from the operand bytes
    always_ff @(posedge clk) begin
        if (eaHiLd) begin
            ea[15:8] <= din;
        end else if (eaLoLd) begin
            ea[7:0] <= din;
        end else if (useEa && writeHi) begin
            // High byte done, low byte goes to ea+1
            ea <= ea + 16'd1;
        end
    end

    assign addr = useEa ? ea : pc;

    // PC only moves on cycles that fetch through it
    assert property (@(posedge clk) disable iff (!rstN)
        pcInc |-> !useEa)
        else $error("kcpuAddr PC step during data access");

endmodule

`default_nettype wire

//--- src/kcpuAlu.sv
`timescale 1ns/1ps
`default_nettype none

module kcpuAlu (
    input  kcpuPkg::aluOpT aluOp,
    input  logic           isWord,
    input  logic [15:0]    opnd,
    input  logic [7:0]     ccIn,
    output logic [15:0]    rslt,
    output logic [7:0]     ccNew
);

    logic [15:0] wordRes;
    logic [15:0] opndW;
    logic [15:0] minVal;
    logic [15:0] maxPos;

    // Full-width arithmetic
    // low byte matches the byte op since carries only move upward
    always_comb begin
        case (aluOp)
            kcpuPkg::aluNeg: wordRes = ~opnd + 16'd1;
            kcpuPkg::aluInc: wordRes = opnd + 16'd1;
            kcpuPkg::aluDec: wordRes = opnd - 16'd1;
            default:         wordRes = opnd;
        endcase
    end

    // Byte results come out zero-extended
    assign rslt = isWord ? wordRes : {8'h00, wordRes[7:0]};

    // Operand and overflow edge values at the active width
    assign opndW  = isWord ? opnd : {8'h00, opnd[7:0]};
    assign minVal = isWord ? 16'h8000 : 16'h0080;
    assign maxPos = isWord ? 16'h7FFF : 16'h007F;

    always_comb begin
        // H and the unused bits pass through
        ccNew = ccIn;
        ccNew[kcpuPkg::ccN] = isWord ? rslt[15] : rslt[7];
        ccNew[kcpuPkg::ccZ] = (rslt == 16'h0000);
        case (aluOp)
            kcpuPkg::aluNeg: begin
                // Only -80h / -8000h overflows
                ccNew[kcpuPkg::ccV] = (opndW == minVal);
                // Borrow out of 0 - x
                ccNew[kcpuPkg::ccC] = (rslt != 16'h0000);
            end
            kcpuPkg::aluInc: begin
                ccNew[kcpuPkg::ccV] = (opndW == maxPos);
            end
            kcpuPkg::aluDec: begin
                ccNew[kcpuPkg::ccV] = (opndW == minVal);
            end
            default: begin
                // Load / store transfer
                ccNew[kcpuPkg::ccV] = 1'b0;
            end
        endcase
    end

    // Byte ops never spill into the upper byte
    always_comb begin
        assert final (isWord || rslt[15:8] == 8'h00)
            else $error("kcpuAlu byte op wrote upper result byte");
    end

endmodule

`default_nettype wire

//--- src/kcpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module kcpuCore #(
    parameter logic [15:0] resetAddr = 16'h0000
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic [7:0]  din,
    output logic [15:0] addr,
    output logic [7:0]  dout,
    output logic        rd,
    output logic        we,
    output logic        opFetch,
    output logic        halted,
    output logic [7:0]  ccOut
);

    // Controller to datapath
    logic            pcInc;
    logic            eaHiLd;
    logic            eaLoLd;
    logic            useEa;
    logic            memLd;
    logic            writeHi;
    logic            regWe;
    logic            ccWe;
    kcpuPkg::aluOpT  aluOp;
    logic            isWord;
    kcpuPkg::regSelT srcSel;
    kcpuPkg::regSelT dstSel;

    // Register file and ALU
    logic [15:0]     opnd;
    logic [15:0]     rslt;
    logic [7:0]      ccNew;

    kcpuCtrl uCtrl (
        .clk     (clk),
        .rstN    (rstN),
        .din     (din),
        .rd      (rd),
        .we      (we),
        .opFetch (opFetch),
        .halted  (halted),
        .pcInc   (pcInc),
        .eaHiLd  (eaHiLd),
        .eaLoLd  (eaLoLd),
        .useEa   (useEa),
        .memLd   (memLd),
        .writeHi (writeHi),
        .regWe   (regWe),
        .ccWe    (ccWe),
        .aluOp   (aluOp),
        .isWord  (isWord),
        .srcSel  (srcSel),
        .dstSel  (dstSel)
    );

    kcpuAddr #(
        .resetAddr (resetAddr)
    ) uAddr (
        .clk     (clk),
        .rstN    (rstN),
        .pcInc   (pcInc),
        .eaHiLd  (eaHiLd),
        .eaLoLd  (eaLoLd),
        .useEa   (useEa),
        .writeHi (writeHi),
        .din     (din),
        .addr    (addr)
    );

    // ALU result is both the register and the store data
    kcpuRegs uRegs (
        .clk     (clk),
        .rstN    (rstN),
        .srcSel  (srcSel),
        .dstSel  (dstSel),
        .regWe   (regWe),
        .ccWe    (ccWe),
        .memLd   (memLd),
        .writeHi (writeHi),
        .wrData  (rslt),
        .ccNew   (ccNew),
        .din     (din),
        .opnd    (opnd),
        .cc      (ccOut),
        .dout    (dout)
    );

    kcpuAlu uAlu (
        .aluOp  (aluOp),
        .isWord (isWord),
        .opnd   (opnd),
        .ccIn   (ccOut),
        .rslt   (rslt),
        .ccNew  (ccNew)
    );

endmodule

`default_nettype wire

//--- src/kcpuCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module kcpuCtrl (
    input  logic            clk,
    input  logic            rstN,
    input  logic [7:0]      din,
    output logic            rd,
    output logic            we,
    output logic            opFetch,
    output logic            halted,
    output logic            pcInc,
    output logic            eaHiLd,
    output logic            eaLoLd,
    output logic            useEa,
    output logic            memLd,
    output logic            writeHi,
    output logic            regWe,
    output logic            ccWe,
    output kcpuPkg::aluOpT  aluOp,
    output logic            isWord,
    output kcpuPkg::regSelT srcSel,
    output kcpuPkg::regSelT dstSel
);

    kcpuPkg::ctrlStateT state;
    kcpuPkg::ctrlStateT nextState;
    logic [7:0]         opReg;
    logic [7:0]         opc;
    kcpuPkg::aluOpT     opAlu;
    kcpuPkg::regSelT    tgt;
    logic               aluGrp;
    logic               isLoad;
    logic               isStore;
    logic               isRmw;
    logic               opWord;

    // Opcode is live on din during sFetch
    assign opc = (state == kcpuPkg::sFetch) ? din : opReg;

    // ALU function
    always_comb begin
        if (opc inside {kcpuPkg::opNegA, kcpuPkg::opNegB, kcpuPkg::opNegM,
                        kcpuPkg::opNegD, kcpuPkg::opNegW}) begin
            opAlu = kcpuPkg::aluNeg;
        end else if (opc inside {kcpuPkg::opIncA, kcpuPkg::opIncB, kcpuPkg::opIncM,
                                 kcpuPkg::opIncD, kcpuPkg::opIncW}) begin
            opAlu = kcpuPkg::aluInc;
        end else if (opc inside {kcpuPkg::opDecA, kcpuPkg::opDecB, kcpuPkg::opDecM,
                                 kcpuPkg::opDecD, kcpuPkg::opDecW}) begin
            opAlu = kcpuPkg::aluDec;
        end else begin
            opAlu = kcpuPkg::aluPass;
        end
    end

    // Target register, memory for the rest
    always_comb begin
        if (opc inside {kcpuPkg::opNegA, kcpuPkg::opIncA, kcpuPkg::opDecA,
                        kcpuPkg::opLdA, kcpuPkg::opStA}) begin
            tgt = kcpuPkg::regA;
        end else if (opc inside {kcpuPkg::opNegB, kcpuPkg::opIncB, kcpuPkg::opDecB,
                                 kcpuPkg::opLdB, kcpuPkg::opStB}) begin
            tgt = kcpuPkg::regB;
        end else if (opc inside {kcpuPkg::opNegD, kcpuPkg::opIncD, kcpuPkg::opDecD,
                                 kcpuPkg::opLdD, kcpuPkg::opStD}) begin
            tgt = kcpuPkg::regD;
        end else if (opc inside {kcpuPkg::opNegW, kcpuPkg::opIncW, kcpuPkg::opDecW,
                                 kcpuPkg::opLdW, kcpuPkg::opStW}) begin
            tgt = kcpuPkg::regW;
        end else begin
            tgt = kcpuPkg::regMem;
        end
    end

    assign aluGrp  = (opAlu != kcpuPkg::aluPass);
    assign isLoad  = opc inside {kcpuPkg::opLdA, kcpuPkg::opLdB,
                                 kcpuPkg::opLdD, kcpuPkg::opLdW};
    assign isStore = opc inside {kcpuPkg::opStA, kcpuPkg::opStB,
                                 kcpuPkg::opStD, kcpuPkg::opStW};
    assign isRmw   = aluGrp && (tgt == kcpuPkg::regMem);
    assign opWord  = (tgt == kcpuPkg::regD) || (tgt == kcpuPkg::regW);

    // Sequencing
    always_comb begin
        case (state)
            kcpuPkg::sFetch: begin
                if (isLoad) begin
                    // Byte immediates skip the high operand
                    nextState = opWord ? kcpuPkg::sOpHi : kcpuPkg::sOpLo;
                end else if (isStore || isRmw) begin
                    nextState = kcpuPkg::sOpHi;
                end else begin
                    // Inherent ops, NOP, HALT, unknown codes
                    nextState = kcpuPkg::sExec;
                end
            end
            kcpuPkg::sOpHi: nextState = kcpuPkg::sOpLo;
            kcpuPkg::sOpLo: begin
                if (isLoad) begin
                    nextState = kcpuPkg::sFetch;
                end else if (isRmw) begin
                    nextState = kcpuPkg::sMemRd;
                end else begin
                    nextState = opWord ? kcpuPkg::sWrHi : kcpuPkg::sWrLo;
                end
            end
            kcpuPkg::sMemRd: nextState = kcpuPkg::sExec;
            kcpuPkg::sExec: begin
                if (isRmw) begin
                    nextState = kcpuPkg::sWrLo;
                end else if (opc == kcpuPkg::opHalt) begin
                    nextState = kcpuPkg::sHalt;
                end else begin
                    nextState = kcpuPkg::sFetch;
                end
            end
            kcpuPkg::sWrHi: nextState = kcpuPkg::sWrLo;
            kcpuPkg::sWrLo: nextState = kcpuPkg::sFetch;
            default:        nextState = kcpuPkg::sHalt;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= kcpuPkg::sFetch;
            opReg <= kcpuPkg::opNop;
        end else begin
            state <= nextState;
            if (state == kcpuPkg::sFetch) begin
                opReg <= din;
            end
        end
    end

    // Bus strobes, no reads while in reset
    assign rd = rstN && (state inside {kcpuPkg::sFetch, kcpuPkg::sOpHi,
                                       kcpuPkg::sOpLo, kcpuPkg::sMemRd});
    assign we      = state inside {kcpuPkg::sWrHi, kcpuPkg::sWrLo};
    assign writeHi = (state == kcpuPkg::sWrHi);
    assign opFetch = (state == kcpuPkg::sFetch);
    assign halted  = (state == kcpuPkg::sHalt);

    // Address path
    assign pcInc  = state inside {kcpuPkg::sFetch, kcpuPkg::sOpHi, kcpuPkg::sOpLo};
    assign eaHiLd = (state == kcpuPkg::sOpHi) && !isLoad;
    assign eaLoLd = (state == kcpuPkg::sOpLo) && !isLoad;
    assign useEa  = state inside {kcpuPkg::sMemRd, kcpuPkg::sWrHi, kcpuPkg::sWrLo};

    // Immediates and the RMW byte go to the operand latch
    assign memLd = ((state == kcpuPkg::sOpHi || state == kcpuPkg::sOpLo) && isLoad)
                   || (state == kcpuPkg::sMemRd);

    // Write-back
    assign regWe = ((state == kcpuPkg::sExec) && aluGrp && !isRmw)
                   || ((state == kcpuPkg::sOpLo) && isLoad);
    assign ccWe  = ((state == kcpuPkg::sExec) && aluGrp)
                   || ((state == kcpuPkg::sOpLo) && isLoad)
                   || ((state == kcpuPkg::sWrLo) && isStore);

    assign aluOp  = opAlu;
    assign isWord = opWord;
    assign srcSel = isLoad ? kcpuPkg::regMem : tgt;
    assign dstSel = tgt;

    assert property (@(posedge clk) disable iff (!rstN) !(rd && we))
        else $error("kcpuCtrl read and write strobes overlap");

    // Only stores and RMW ops reach the write states
    assert property (@(posedge clk) disable iff (!rstN)
        we |-> (isStore || isRmw))
        else $error("kcpuCtrl write outside a store or RMW");

    // Halt only leaves through reset
    assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
        else $error("kcpuCtrl left halt without reset");

endmodule

`default_nettype wire

//--- src/kcpuPkg.sv
`default_nettype none

package kcpuPkg;

    // Byte unary group, A / B / extended memory per function
    localparam logic [7:0] opNegA = 8'h86;
    localparam logic [7:0] opNegB = 8'h87;
    localparam logic [7:0] opNegM = 8'h88;
    localparam logic [7:0] opIncA = 8'h89;
    localparam logic [7:0] opIncB = 8'h8A;
    localparam logic [7:0] opIncM = 8'h8B;
    localparam logic [7:0] opDecA = 8'h8C;
    localparam logic [7:0] opDecB = 8'h8D;
    localparam logic [7:0] opDecM = 8'h8E;

    // Word unary group on D and W
    localparam logic [7:0] opNegD = 8'hC4;
    localparam logic [7:0] opNegW = 8'hC5;
    localparam logic [7:0] opIncD = 8'hC6;
    localparam logic [7:0] opIncW = 8'hC7;
    localparam logic [7:0] opDecD = 8'hC8;
    localparam logic [7:0] opDecW = 8'hC9;

    // Immediate loads
    localparam logic [7:0] opLdA = 8'h10;
    localparam logic [7:0] opLdB = 8'h11;
    localparam logic [7:0] opLdD = 8'h12;
    localparam logic [7:0] opLdW = 8'h13;

    // Extended stores
    localparam logic [7:0] opStA = 8'h18;
    localparam logic [7:0] opStB = 8'h19;
    localparam logic [7:0] opStD = 8'h1A;
    localparam logic [7:0] opStW = 8'h1B;

    localparam logic [7:0] opNop  = 8'h01;
    localparam logic [7:0] opHalt = 8'h3F;

    // Condition code bit positions
    localparam int ccC = 0;
    localparam int ccV = 1;
    localparam int ccZ = 2;
    localparam int ccN = 3;
    localparam int ccH = 5;

    typedef enum logic [1:0] {aluPass, aluNeg, aluInc, aluDec} aluOpT;

    typedef enum logic [2:0] {regA, regB, regD, regW, regMem} regSelT;

    // D as one word, or ab[1] = A and ab[0] = B
    typedef union packed {
        logic [15:0]     word;
        logic [1:0][7:0] ab;
    } dRegT;

    typedef enum logic [3:0] {
        sFetch, sOpHi, sOpLo, sMemRd, sExec, sWrHi, sWrLo, sHalt
    } ctrlStateT;

endpackage

`default_nettype wire

//--- src/kcpuRegs.sv
`timescale 1ns/1ps
`default_nettype none

module kcpuRegs (
    input  logic             clk,
    input  logic             rstN,
    input  kcpuPkg::regSelT  srcSel,
    input  kcpuPkg::regSelT  dstSel,
    input  logic             regWe,
    input  logic             ccWe,
    input  logic             memLd,
    input  logic             writeHi,
    input  logic [15:0]      wrData,
    input  logic [7:0]       ccNew,
    input  logic [7:0]       din,
    output logic [15:0]      opnd,
    output logic [7:0]       cc,
    output logic [7:0]       dout
);

    kcpuPkg::dRegT dReg;
    logic [15:0]   wReg;
    logic [7:0]    ccReg;
    // Last byte read off the bus
    logic [7:0]    memOpnd;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dReg.word <= 16'h0000;
            wReg      <= 16'h0000;
            ccReg     <= 8'h00;
        end else begin
            if (regWe) begin
                case (dstSel)
                    // A and B land inside D
                    kcpuPkg::regA: dReg.ab[1] <= wrData[7:0];
                    kcpuPkg::regB: dReg.ab[0] <= wrData[7:0];
                    kcpuPkg::regD: dReg.word  <= wrData;
                    kcpuPkg::regW: wReg       <= wrData;
                    default: ;
                endcase
            end
            if (ccWe) begin
                ccReg <= ccNew;
            end
        end
    end

    // Memory operand, one byte per read
    always_ff @(posedge clk) begin
        if (memLd) begin
            memOpnd <= din;
        end
    end

    // Operand select
    always_comb begin
        case (srcSel)
            kcpuPkg::regA: opnd = {8'h00, dReg.ab[1]};
            kcpuPkg::regB: opnd = {8'h00, dReg.ab[0]};
            kcpuPkg::regD: opnd = dReg.word;
            kcpuPkg::regW: opnd = wReg;
            // Immediate still on the bus, so forward it
            default:       opnd = memLd ? {memOpnd, din} : {8'h00, memOpnd};
        endcase
    end

    assign cc = ccReg;

    // Store byte, high half first on word stores
    assign dout = writeHi ? wrData[15:8] : wrData[7:0];

    // Memory results leave through dout only
    assert property (@(posedge clk) disable iff (!rstN)
        !(regWe && dstSel == kcpuPkg::regMem))
        else $error("kcpuRegs register write aimed at memory");

endmodule

`default_nettype wire

//--- testbench/kcpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module kcpuTb;

    localparam logic [15:0] startAddr = 16'h0000;
    localparam int numInstr = 240;
    localparam int haltLimit = 6000;
    localparam int fetchLimit = 8;

    logic        clk;
    logic        rstN;
    logic [7:0]  din;
    logic [15:0] addr;
    logic [7:0]  dout;
    logic        rd;
    logic        we;
    logic        opFetch;
    logic        halted;
    logic [7:0]  ccOut;

    // Flat 64 KiB memory, program at 0000h, data page at 8000h
    logic [7:0]  mem [0:65535];
    logic [15:0] progPtr;

    // ISA model state
    logic [7:0]  mA;
    logic [7:0]  mB;
    logic [15:0] mW;
    logic [7:0]  mCc;
    logic [7:0]  modelPage [0:255];
    logic [15:0] expAddr [$];
    logic [7:0]  expData [$];
    // Opcode addresses in program order
    logic [15:0] expFetch [$];

    integer seed;
    int     errors;
    int     timeouts;
    int     writesSeen;

    kcpuCore #(
        .resetAddr (startAddr)
    ) dut (
        .clk     (clk),
        .rstN    (rstN),
        .din     (din),
        .addr    (addr),
        .dout    (dout),
        .rd      (rd),
        .we      (we),
        .opFetch (opFetch),
        .halted  (halted),
        .ccOut   (ccOut)
    );

    always #5 clk = ~clk;

    // Zero-wait memory, read is combinational
    assign din = mem[addr];

    always @(posedge clk) begin
        if (rstN && we) begin
            mem[addr] <= dout;
        end
    end

    task automatic reportMismatch(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Random byte, overflow edges forced about a quarter of the time
    function automatic logic [7:0] edgeByte();
        if (pick(4) != 0) begin
            return 8'(pick(256));
        end
        case (pick(4))
            0:       return 8'h7F;
            1:       return 8'h80;
            2:       return 8'h00;
            default: return 8'hFF;
        endcase
    endfunction

    function automatic logic [15:0] edgeWord();
        case (pick(6))
            0:       return 16'h7FFF;
            1:       return 16'h8000;
            2:       return 16'h0000;
            3:       return 16'hFFFF;
            4:       return {edgeByte(), edgeByte()};
            default: return 16'(pick(65536));
        endcase
    endfunction

    task automatic emit(input logic [7:0] b);
        mem[progPtr] = b;
        progPtr = progPtr + 16'd1;
    endtask

    // Opcode byte, the core must fetch it from this address
    task automatic emitOpcode(input logic [7:0] op);
        expFetch.push_back(progPtr);
        emit(op);
    endtask

    // Queue a bus write and mirror it in the model page
    task automatic expectWrite(input logic [15:0] a, input logic [7:0] d);
        expAddr.push_back(a);
        expData.push_back(d);
        modelPage[a[7:0]] = d;
    endtask

    // Loads and stores: N and Z from the value, V cleared, C kept
    task automatic setTransferFlags(input logic wide, input logic [15:0] val);
        mCc[kcpuPkg::ccN] = wide ? val[15] : val[7];
        mCc[kcpuPkg::ccZ] = wide ? (val == 16'h0000) : (val[7:0] == 8'h00);
        mCc[kcpuPkg::ccV] = 1'b0;
    endtask

    // func 0 NEG, 1 INC, 2 DEC; val already cut to width
    task automatic applyUnary(input int func, input logic wide, input logic [15:0] val,
                              output logic [15:0] res);
        logic [15:0] mask;
        logic [15:0] sign;
        mask = wide ? 16'hFFFF : 16'h00FF;
        sign = wide ? 16'h8000 : 16'h0080;
        case (func)
            0:       res = (16'h0000 - val) & mask;
            1:       res = (val + 16'd1) & mask;
            default: res = (val - 16'd1) & mask;
        endcase
        // INC overflows from max positive, NEG and DEC from min negative
        mCc[kcpuPkg::ccV] = (func == 1) ? (val == sign - 16'd1) : (val == sign);
        if (func == 0) begin
            mCc[kcpuPkg::ccC] = (res != 16'h0000);
        end
        mCc[kcpuPkg::ccN] = ((res & sign) != 16'h0000);
        mCc[kcpuPkg::ccZ] = (res == 16'h0000);
    endtask

    function automatic logic [7:0] byteOpcode(input int func, input int tgt);
        case (func)
            0: return (tgt == 0) ? kcpuPkg::opNegA : (tgt == 1) ? kcpuPkg::opNegB
                                                               : kcpuPkg::opNegM;
            1: return (tgt == 0) ? kcpuPkg::opIncA : (tgt == 1) ? kcpuPkg::opIncB
                                                               : kcpuPkg::opIncM;
            default: return (tgt == 0) ? kcpuPkg::opDecA : (tgt == 1) ? kcpuPkg::opDecB
                                                                     : kcpuPkg::opDecM;
        endcase
    endfunction

    function automatic logic [7:0] wordOpcode(input int func, input int onW);
        case (func)
            0:       return onW ? kcpuPkg::opNegW : kcpuPkg::opNegD;
            1:       return onW ? kcpuPkg::opIncW : kcpuPkg::opIncD;
            default: return onW ? kcpuPkg::opDecW : kcpuPkg::opDecD;
        endcase
    endfunction

    // tgt 0 A, 1 B, 2 D, 3 W
    task automatic loadImm(input int tgt, input logic [15:0] val);
        case (tgt)
            0: begin
                emitOpcode(kcpuPkg::opLdA);
                emit(val[7:0]);
                mA = val[7:0];
            end
            1: begin
                emitOpcode(kcpuPkg::opLdB);
                emit(val[7:0]);
                mB = val[7:0];
            end
            2: begin
                // Big endian immediate, D high byte is A
                emitOpcode(kcpuPkg::opLdD);
                emit(val[15:8]);
                emit(val[7:0]);
                mA = val[15:8];
                mB = val[7:0];
            end
            default: begin
                emitOpcode(kcpuPkg::opLdW);
                emit(val[15:8]);
                emit(val[7:0]);
                mW = val;
            end
        endcase
        setTransferFlags(tgt >= 2, val);
    endtask

    // tgt 0 A, 1 B, 2 extended memory byte
    task automatic byteUnary(input int func, input int tgt);
        logic [15:0] ea;
        logic [15:0] res;
        emitOpcode(byteOpcode(func, tgt));
        if (tgt == 2) begin
            ea = 16'h8000 + 16'(pick(256));
            emit(ea[15:8]);
            emit(ea[7:0]);
            applyUnary(func, 1'b0, {8'h00, modelPage[ea[7:0]]}, res);
            expectWrite(ea, res[7:0]);
        end else if (tgt == 0) begin
            applyUnary(func, 1'b0, {8'h00, mA}, res);
            mA = res[7:0];
        end else begin
            applyUnary(func, 1'b0, {8'h00, mB}, res);
            mB = res[7:0];
        end
    endtask

    task automatic wordUnary(input int func, input int onW);
        logic [15:0] res;
        emitOpcode(wordOpcode(func, onW));
        if (onW != 0) begin
            applyUnary(func, 1'b1, mW, res);
            mW = res;
        end else begin
            applyUnary(func, 1'b1, {mA, mB}, res);
            mA = res[15:8];
            mB = res[7:0];
        end
    endtask

    task automatic storeReg(input int tgt);
        logic        wide;
        logic [15:0] ea;
        logic [15:0] val;
        wide = (tgt >= 2);
        // Word stores keep ea+1 inside the page
        ea = 16'h8000 + 16'(wide ? pick(255) : pick(256));
        case (tgt)
            0: begin
                emitOpcode(kcpuPkg::opStA);
                val = {8'h00, mA};
            end
            1: begin
                emitOpcode(kcpuPkg::opStB);
                val = {8'h00, mB};
            end
            2: begin
                emitOpcode(kcpuPkg::opStD);
                val = {mA, mB};
            end
            default: begin
                emitOpcode(kcpuPkg::opStW);
                val = mW;
            end
        endcase
        emit(ea[15:8]);
        emit(ea[7:0]);
        if (wide) begin
            expectWrite(ea, val[15:8]);
            expectWrite(ea + 16'd1, val[7:0]);
        end else begin
            expectWrite(ea, val[7:0]);
        end
        setTransferFlags(wide, val);
    endtask

    task automatic buildImage();
        int         i;
        int         k;
        logic [7:0] b;
        // Background pattern over the whole address
        for (i = 0; i < 65536; i++) begin
            mem[i] = 8'(i >> 8) ^ 8'(i) ^ 8'hA5;
        end
        for (i = 0; i < 256; i++) begin
            b = edgeByte();
            mem[16'h8000 + i] = b;
            modelPage[i] = b;
        end
        progPtr = startAddr;
        for (k = 0; k < numInstr; k++) begin
            case (pick(11))
                0, 1:    loadImm(pick(2), {8'h00, edgeByte()});
                2:       loadImm(2 + pick(2), edgeWord());
                3, 4:    byteUnary(pick(3), pick(2));
                5:       wordUnary(pick(3), pick(2));
                6:       byteUnary(pick(3), 2);
                7:       storeReg(pick(2));
                8:       storeReg(2 + pick(2));
                // Unknown code 00h runs as NOP
                9:       emitOpcode((pick(2) != 0) ? kcpuPkg::opNop : 8'h00);
                default: begin
                    // A and B loads seen through D
                    loadImm(0, {8'h00, edgeByte()});
                    loadImm(1, {8'h00, edgeByte()});
                    wordUnary(pick(3), 0);
                    storeReg(2);
                end
            endcase
        end
        // Dump every register before stopping
        for (k = 0; k < 4; k++) begin
            storeReg(k);
        end
        emitOpcode(kcpuPkg::opHalt);
    endtask

    task automatic comparePage();
        int i;
        for (i = 0; i < 256; i++) begin
            assert (mem[16'h8000 + i] == modelPage[i])
                else reportMismatch($sformatf("page byte %h is %h, expected %h",
                                              16'h8000 + i, mem[16'h8000 + i], modelPage[i]));
        end
    endtask

    // Bus write and opcode fetch monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rstN && we) begin
            writesSeen++;
            assert (expAddr.size() > 0)
                else reportMismatch($sformatf("write of %h to %h with none expected",
                                              dout, addr));
            if (expAddr.size() > 0) begin
                assert (addr == expAddr[0] && dout == expData[0])
                    else reportMismatch($sformatf("write %h to %h, expected %h to %h",
                                                  dout, addr, expData[0], expAddr[0]));
                void'(expAddr.pop_front());
                void'(expData.pop_front());
            end
        end
        if (rstN && opFetch) begin
            assert (expFetch.size() > 0)
                else reportMismatch($sformatf("opcode fetch at %h past the program end",
                                              addr));
            if (expFetch.size() > 0) begin
                assert (rd && addr == expFetch[0])
                    else reportMismatch($sformatf("opcode fetch at %h rd %b, expected at %h",
                                                  addr, rd, expFetch[0]));
                void'(expFetch.pop_front());
            end
        end
    end

    initial begin
        int waited;
        seed = 15250;
        errors = 0;
        timeouts = 0;
        writesSeen = 0;
        clk = 1'b0;
        rstN = 1'b0;
        mA = 8'h00;
        mB = 8'h00;
        mW = 16'h0000;
        mCc = 8'h00;
        buildImage();

        // Two rising edges in reset
        @(posedge clk);
        @(negedge clk);
        assert (!rd && !we && !halted)
            else reportMismatch("rd, we or halted high during reset");
        @(posedge clk);
        #1 rstN = 1'b1;

        waited = 0;
        @(negedge clk);
        assert (!we && !halted)
            else reportMismatch("we or halted high in the first cycle after reset");
        while (!opFetch && waited < fetchLimit) begin
            @(negedge clk);
            waited++;
        end

        if (!opFetch) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for the first opcode fetch", waited);
        end else begin
            assert (addr == startAddr)
                else reportMismatch($sformatf("first fetch at %h, expected %h",
                                              addr, startAddr));
            waited = 0;
            while (!halted && waited < haltLimit) begin
                @(negedge clk);
                waited++;
            end
            if (!halted) begin
                timeouts++;
                $display("Timed out after %0d cycles waiting for the core to halt", waited);
            end else begin
                assert (ccOut == mCc)
                    else reportMismatch($sformatf("final cc %h, expected %h", ccOut, mCc));
                assert (expAddr.size() == 0)
                    else reportMismatch($sformatf("%0d expected writes never seen",
                                                  expAddr.size()));
                assert (expFetch.size() == 0)
                    else reportMismatch($sformatf("%0d expected fetches never seen",
                                                  expFetch.size()));
                // Bus stays quiet while halted
                repeat (20) begin
                    @(negedge clk);
                    assert (!rd && !we && halted)
                        else reportMismatch("bus activity after halt");
                end
                comparePage();
            end
        end

        $display("Writes checked %0d, errors %0d, timeouts %0d",
                 writesSeen, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
